// File: src/video_cfg.svh
/* Video mode configuration */

`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// ==============================
// Horizontal timing, in clocks
// ==============================

// Visible pixels on each line
`define VID_H_DISPLAY 256
// Blank clocks between the end of the picture and the sync pulse
`define VID_H_FP 8
// Width of the horizontal sync pulse
`define VID_H_PULSE 40
// Blank clocks between the sync pulse and the start of the picture
`define VID_H_BP 16

// ==============================
// Vertical timing, in lines
// ==============================

// Visible lines in each frame
`define VID_V_DISPLAY 256
// Blank lines after the picture and before vertical sync
`define VID_V_FP 8
// Lines covered by the vertical sync pulse
`define VID_V_PULSE 8
// Blank lines after vertical sync and before the picture
`define VID_V_BP 16

// ==============================
// Field widths and pipeline
// ==============================

// Width of both raster counters, with room for larger modes
`define VID_COUNT_W 12
// Register stages between the timing generator and the formatter
`define VID_PIPE_STAGES 2

`endif

// File: src/video_timing_pkg.sv
/* Raster timing types */

`include "video_cfg.svh"

package video_timing_pkg;

  // Pixel position within a line or line position within a frame
  typedef logic [`VID_COUNT_W-1:0] count_t;

  // Per-pixel timing flags, travelling alongside the colour data
  // Both sync flags are active low, de and border are active high
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
    logic border;
  } timing_flags_t;

  // Flag value seen outside the active picture and during reset
  // Sync is inactive (high) and no pixel is being displayed
  localparam timing_flags_t FLAGS_IDLE = '{
    hsync:  1'b1,
    vsync:  1'b1,
    de:     1'b0,
    border: 1'b0
  };

endpackage

// File: src/video_pixel_pkg.sv
/* Pixel colour types */

package video_pixel_pkg;

  // ==============================
  // Input colour
  // ==============================

  // Colour as it arrives from the pixel source, one nibble per channel
  // Red sits in the top nibble so the packed value reads as 0xRGB
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb444_t;

  // ==============================
  // Output colour
  // ==============================

  // Colour as driven to the display, one byte per channel
  // Same channel order as the input type
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // Full-scale value on every channel, used for the picture frame
  localparam rgb888_t RGB888_WHITE = '{r: 8'hff, g: 8'hff, b: 8'hff};

endpackage

// File: src/video_timing_gen.sv
/* Raster timing generator */

`include "video_cfg.svh"

module video_timing_gen
  import video_timing_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  output timing_flags_t flags
);

  // ==============================
  // Raster geometry
  // ==============================

  // Line and frame lengths, including all blanking
  localparam count_t H_TOTAL = count_t'(`VID_H_DISPLAY + `VID_H_FP + `VID_H_PULSE + `VID_H_BP);
  localparam count_t V_TOTAL = count_t'(`VID_V_DISPLAY + `VID_V_FP + `VID_V_PULSE + `VID_V_BP);

  // Each line and each frame starts with its sync pulse
  localparam count_t H_SYNC_END = count_t'(`VID_H_PULSE);
  localparam count_t V_SYNC_END = count_t'(`VID_V_PULSE);

  // First and last active position on each axis
  // The active window follows the back porch directly
  localparam count_t H_ACT_FIRST = count_t'(`VID_H_PULSE + `VID_H_BP);
  localparam count_t H_ACT_LAST  = count_t'(`VID_H_PULSE + `VID_H_BP + `VID_H_DISPLAY - 1);
  localparam count_t V_ACT_FIRST = count_t'(`VID_V_PULSE + `VID_V_BP);
  localparam count_t V_ACT_LAST  = count_t'(`VID_V_PULSE + `VID_V_BP + `VID_V_DISPLAY - 1);

  // Current pixel within the line and current line within the frame
  count_t h_count;
  count_t v_count;

  // Decoded state of the current counter position
  logic h_wrap;
  logic v_wrap;
  logic h_active;
  logic v_active;
  logic h_edge;
  logic v_edge;
  timing_flags_t flags_next;

  // ==============================
  // Raster counters
  // ==============================

  assign h_wrap = (h_count == H_TOTAL - count_t'(1));
  assign v_wrap = (v_count == V_TOTAL - count_t'(1));

  // The line counter steps once per line, on the last pixel
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      h_count <= '0;
      v_count <= '0;
    end
    else
    begin
      if (h_wrap)
      begin
        h_count <= '0;
        if (v_wrap)
          v_count <= '0;
        else
          v_count <= v_count + count_t'(1);
      end
      else
      begin
        h_count <= h_count + count_t'(1);
      end
    end
  end

  // ==============================
  // Window decode
  // ==============================

  assign h_active = (h_count >= H_ACT_FIRST) && (h_count <= H_ACT_LAST);
  assign v_active = (v_count >= V_ACT_FIRST) && (v_count <= V_ACT_LAST);

  // Outermost column and row of the picture
  assign h_edge = (h_count == H_ACT_FIRST) || (h_count == H_ACT_LAST);
  assign v_edge = (v_count == V_ACT_FIRST) || (v_count == V_ACT_LAST);

  always_comb
  begin
    // Sync pulses sit at the start of the line and of the frame
    flags_next.hsync  = (h_count >= H_SYNC_END);
    flags_next.vsync  = (v_count >= V_SYNC_END);
    flags_next.de     = h_active && v_active;
    // Only displayed pixels may be marked, so border implies de
    flags_next.border = h_active && v_active && (h_edge || v_edge);
  end

  // One register stage between counter state and flags
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      flags <= FLAGS_IDLE;
    else
      flags <= flags_next;
  end

endmodule

// File: src/pixel_delay_line.sv
/* Pipeline delay line */

module pixel_delay_line #(
  parameter type      payload_t   = logic,
  parameter int       STAGES      = 2,
  parameter payload_t RESET_VALUE = '0
) (
  input  logic     clk,
  input  logic     reset_n,
  input  payload_t din,
  output payload_t dout
);

  // One register per stage, index 0 is loaded from the input
  payload_t stage_q [STAGES];

  // ==============================
  // Shift chain
  // ==============================

  // Every stage moves on each clock, so the line holds STAGES items
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < STAGES; i++)
      begin
        stage_q[i] <= RESET_VALUE;
      end
    end
    else
    begin
      stage_q[0] <= din;
      for (int i = 1; i < STAGES; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Oldest item leaves from the end of the chain
  assign dout = stage_q[STAGES-1];

endmodule

// File: src/pixel_formatter.sv
/* Output pixel formatter */

module pixel_formatter
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  input  timing_flags_t flags,
  input  rgb444_t       pixel_in,
  output logic          hsync,
  output logic          vsync,
  output logic          de,
  output logic [7:0]    r,
  output logic [7:0]    g,
  output logic [7:0]    b
);

  // Colour for the current pixel before the output register
  rgb888_t colour_next;

  // ==============================
  // Colour selection
  // ==============================

  always_comb
  begin
    if (flags.border)
    begin
      // The outermost ring of the picture is drawn as a white frame
      colour_next = RGB888_WHITE;
    end
    else
    begin
      // Repeating the nibble maps 0x0 to 0x00 and 0xf to 0xff exactly
      colour_next.r = {pixel_in.r, pixel_in.r};
      colour_next.g = {pixel_in.g, pixel_in.g};
      colour_next.b = {pixel_in.b, pixel_in.b};
    end
  end

  // Final register stage, sync and enable pass through unchanged
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      de    <= 1'b0;
      r     <= '0;
      g     <= '0;
      b     <= '0;
    end
    else
    begin
      hsync <= flags.hsync;
      vsync <= flags.vsync;
      de    <= flags.de;
      r     <= colour_next.r;
      g     <= colour_next.g;
      b     <= colour_next.b;
    end
  end

endmodule

// File: src/video_out_top.sv
/* Video output stage */

`include "video_cfg.svh"

module video_out_top
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic [3:0] r4,
  input  logic [3:0] g4,
  input  logic [3:0] b4,
  output logic       hsync,
  output logic       vsync,
  output logic       de,
  output logic [7:0] r,
  output logic [7:0] g,
  output logic [7:0] b
);

  // Flags straight from the timing generator and after the delay line
  timing_flags_t flags_gen;
  timing_flags_t flags_dly;

  // Incoming colour and its delayed copy
  rgb444_t pixel_raw;
  rgb444_t pixel_dly;

  assign pixel_raw = '{r: r4, g: g4, b: b4};

  // ==============================
  // Timing path
  // ==============================

  video_timing_gen u_timing (
    .clk     (clk),
    .reset_n (reset_n),
    .flags   (flags_gen)
  );

  pixel_delay_line #(
    .payload_t   (timing_flags_t),
    .STAGES      (`VID_PIPE_STAGES),
    .RESET_VALUE (FLAGS_IDLE)
  ) flag_delay (
    .clk     (clk),
    .reset_n (reset_n),
    .din     (flags_gen),
    .dout    (flags_dly)
  );

  // ==============================
  // Colour path
  // ==============================

  // Same depth as the flag path so each colour keeps its own flags
  pixel_delay_line #(
    .payload_t   (rgb444_t),
    .STAGES      (`VID_PIPE_STAGES),
    .RESET_VALUE ('0)
  ) pixel_delay (
    .clk     (clk),
    .reset_n (reset_n),
    .din     (pixel_raw),
    .dout    (pixel_dly)
  );

  pixel_formatter u_formatter (
    .clk      (clk),
    .reset_n  (reset_n),
    .flags    (flags_dly),
    .pixel_in (pixel_dly),
    .hsync    (hsync),
    .vsync    (vsync),
    .de       (de),
    .r        (r),
    .g        (g),
    .b        (b)
  );

endmodule

// File: tests/tb_video_out.sv
/* Video output testbench */

`include "video_cfg.svh"

module tb_video_out;
  timeunit 1ns;
  timeprecision 1ps;

  // ==============================
  // Raster numbers and table
  // ==============================

  localparam int HALF_PERIOD   = 10;
  localparam int RESET_CYCLES  = 16;
  localparam int H_TOTAL       = `VID_H_DISPLAY + `VID_H_FP + `VID_H_PULSE + `VID_H_BP;
  localparam int V_TOTAL       = `VID_V_DISPLAY + `VID_V_FP + `VID_V_PULSE + `VID_V_BP;
  localparam int FRAME_CLKS    = H_TOTAL * V_TOTAL;
  localparam int ENTRY_TIMEOUT = FRAME_CLKS;

  localparam int MODE_FIXED  = 0;
  localparam int MODE_RANDOM = 1;
  localparam int WAIT_VFALLS = 0;
  localparam int WAIT_RUNS   = 1;
  localparam int NUM_TESTS   = 6;

  // Each entry runs until its target count of vsync falls or de runs is reached
  string       tab_name   [NUM_TESTS] = '{"frame_sync", "fixed_colour_a", "fixed_colour_b",
                                          "random_colour", "random_frame_end", "next_frame"};
  int          tab_mode   [NUM_TESTS] = '{MODE_FIXED, MODE_FIXED, MODE_FIXED,
                                          MODE_RANDOM, MODE_RANDOM, MODE_FIXED};
  logic [11:0] tab_colour [NUM_TESTS] = '{12'h000, 12'h5a3, 12'hf0c,
                                          12'h000, 12'h000, 12'h1e7};
  int          tab_wait   [NUM_TESTS] = '{WAIT_VFALLS, WAIT_RUNS, WAIT_RUNS,
                                          WAIT_RUNS, WAIT_VFALLS, WAIT_RUNS};
  int          tab_target [NUM_TESTS] = '{1, 64, 128, 255, 2, 56};

  logic       clk = 1'b0;
  logic       reset_n;
  logic [3:0] r4;
  logic [3:0] g4;
  logic [3:0] b4;
  logic       hsync;
  logic       vsync;
  logic       de;
  logic [7:0] r;
  logic [7:0] g;
  logic [7:0] b;

  int seed = 89065;

  // Colours driven on the last three rising edges with the newest first
  logic [11:0] colour_hist [3] = '{12'h000, 12'h000, 12'h000};

  // State of the output monitor that is kept from one cycle to the next
  logic prev_hsync = 1'b1;
  logic prev_vsync = 1'b1;
  logic prev_de    = 1'b0;
  logic h_fall_seen = 1'b0;
  int   cycle_count = 0;
  int   last_h_fall;
  int   last_v_fall;
  int   last_de_rise;
  int   h_low_len;
  int   v_low_len;
  int   v_fall_count = 0;
  int   runs_in_frame = 0;
  int   run_pos = 0;
  int   colour_checks = 0;
  int   border_checks = 0;

  always #HALF_PERIOD clk = ~clk;

  video_out_top DUT (
    .clk     (clk),
    .reset_n (reset_n),
    .r4      (r4),
    .g4      (g4),
    .b4      (b4),
    .hsync   (hsync),
    .vsync   (vsync),
    .de      (de),
    .r       (r),
    .g       (g),
    .b       (b)
  );

  // ==============================
  // Checking helpers
  // ==============================

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input string what, input int expected,
                             input int actual);
    assert (actual == expected)
    else
    begin
      abort_run($sformatf("CHECK FAILED: test %s, %s expected 0x%0h actual 0x%0h",
                          name, what, expected, actual));
    end
  endtask

  // A nibble n becomes the byte 0xnn that equals n times 17
  function automatic logic [7:0] expand_nibble(input logic [3:0] n);
    return 8'(n) * 8'd17;
  endfunction

  function automatic logic entry_done(input int idx);
    if (tab_wait[idx] == WAIT_VFALLS)
      return (v_fall_count >= tab_target[idx]);
    else
      return (runs_in_frame >= tab_target[idx]);
  endfunction

  // Tracks sync and enable runs and checks the pixel of the current cycle
  task automatic observe_outputs(input string name, input logic [11:0] exp_colour);
    logic       border;
    logic [7:0] exp_r;
    logic [7:0] exp_g;
    logic [7:0] exp_b;
    cycle_count++;
    if (prev_hsync && !hsync)
    begin
      if (h_fall_seen)
        check_value(name, "hsync period", H_TOTAL, cycle_count - last_h_fall);
      h_fall_seen = 1'b1;
      last_h_fall = cycle_count;
      h_low_len   = 0;
    end
    if (!hsync)
      h_low_len++;
    if (!prev_hsync && hsync && h_fall_seen)
      check_value(name, "hsync low width", `VID_H_PULSE, h_low_len);

    // A new frame starts at every vsync fall
    if (prev_vsync && !vsync)
    begin
      if (v_fall_count > 0)
      begin
        check_value(name, "vsync period", FRAME_CLKS, cycle_count - last_v_fall);
        check_value(name, "de runs per frame", `VID_V_DISPLAY, runs_in_frame);
      end
      v_fall_count++;
      last_v_fall   = cycle_count;
      v_low_len     = 0;
      runs_in_frame = 0;
    end
    if (!vsync)
      v_low_len++;
    if (!prev_vsync && vsync && v_fall_count > 0)
      check_value(name, "vsync low width", `VID_V_PULSE * H_TOTAL, v_low_len);

    if (de && !prev_de)
    begin
      assert (v_fall_count > 0)
      else
      begin
        abort_run("Display enable went high before the first vertical sync");
      end
      if (runs_in_frame > 0)
        check_value(name, "de run spacing", H_TOTAL, cycle_count - last_de_rise);
      last_de_rise = cycle_count;
      run_pos      = 0;
    end
    else if (de)
    begin
      run_pos++;
    end
    if (!de && prev_de)
    begin
      check_value(name, "de run length", `VID_H_DISPLAY, run_pos + 1);
      runs_in_frame++;
    end

    // The outermost ring of the picture is white and the rest follows the input
    if (de)
    begin
      border = (run_pos == 0) || (run_pos == `VID_H_DISPLAY - 1) ||
               (runs_in_frame == 0) || (runs_in_frame == `VID_V_DISPLAY - 1);
      if (border)
      begin
        exp_r = 8'hff;
        exp_g = 8'hff;
        exp_b = 8'hff;
        border_checks++;
      end
      else
      begin
        exp_r = expand_nibble(exp_colour[11:8]);
        exp_g = expand_nibble(exp_colour[7:4]);
        exp_b = expand_nibble(exp_colour[3:0]);
        colour_checks++;
      end
      check_value(name, "red", int'(exp_r), int'(r));
      check_value(name, "green", int'(exp_g), int'(g));
      check_value(name, "blue", int'(exp_b), int'(b));
    end
    prev_hsync = hsync;
    prev_vsync = vsync;
    prev_de    = de;
  endtask

  // Drives one colour on the rising edge and checks the outputs at the falling edge
  task automatic run_cycle(input string name, input int mode, input logic [11:0] fixed_colour);
    logic [11:0] next_colour;
    logic [11:0] exp_colour;
    int          rnd;
    @(posedge clk);
    if (mode == MODE_RANDOM)
    begin
      rnd = $random(seed);
      next_colour = rnd[11:0];
    end
    else
    begin
      next_colour = fixed_colour;
    end
    // Output colour after this edge comes from the drive three edges back
    exp_colour     = colour_hist[2];
    colour_hist[2] = colour_hist[1];
    colour_hist[1] = colour_hist[0];
    colour_hist[0] = next_colour;
    r4 <= next_colour[11:8];
    g4 <= next_colour[7:4];
    b4 <= next_colour[3:0];
    @(negedge clk);
    observe_outputs(name, exp_colour);
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial
  begin
    int   waited;
    logic reached;
    reset_n = 1'b0;
    r4      = 4'h0;
    g4      = 4'h0;
    b4      = 4'h0;

    // Outputs must sit at their idle values for the whole reset
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(negedge clk);
      check_value("reset_state", "hsync", 1, int'(hsync));
      check_value("reset_state", "vsync", 1, int'(vsync));
      check_value("reset_state", "de", 0, int'(de));
      check_value("reset_state", "red", 0, int'(r));
      check_value("reset_state", "green", 0, int'(g));
      check_value("reset_state", "blue", 0, int'(b));
    end
    @(posedge clk);
    reset_n <= 1'b1;

    for (int t = 0; t < NUM_TESTS; t++)
    begin
      waited  = 0;
      reached = entry_done(t);
      while (!reached && waited < ENTRY_TIMEOUT)
      begin
        run_cycle(tab_name[t], tab_mode[t], tab_colour[t]);
        waited++;
        reached = entry_done(t);
      end
      if (!reached)
        abort_run($sformatf("Timeout: test %s did not reach its target within %0d clocks",
                            tab_name[t], ENTRY_TIMEOUT));
      else
        $display("Test %s done after %0d clocks", tab_name[t], waited);
    end

    // Both kinds of pixel must have been seen for the run to count
    if (colour_checks > 0 && border_checks > 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
    begin
      abort_run("No colour or no border pixels were checked during the run");
    end
  end

endmodule

// File: video_out.f
+incdir+src
src/video_timing_pkg.sv
src/video_pixel_pkg.sv
src/video_timing_gen.sv
src/pixel_delay_line.sv
src/pixel_formatter.sv
src/video_out_top.sv
tests/tb_video_out.sv

// File: run.sh
#!/bin/sh
# Build the video output testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_video_out -f video_out.f -o tb_video_out
./obj_dir/tb_video_out
